//--- build.f
common/int_mem_pkg.sv
verilog/bus_arbiter.sv
int_mem/boot_rom.sv
int_mem/boot_loader.sv
int_mem/dual_port_ram.sv
int_mem/int_mem.sv
verification/int_mem_tb.sv

//--- verification/int_mem_tb.sv
`default_nettype none

module int_mem_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_BOOT_READS = 16;
   localparam int N_RW = 100;
   localparam int N_IREADS = 16;
   localparam int N_REMAP = 16;
   localparam int N_TRANS = 2 + N_BOOT_READS + 2 * N_RW + N_IREADS + 3 * N_REMAP + 1
                            + int_mem_pkg::BOOT_WORDS;
   localparam int TIMEOUT_CYCLES = 40 * N_TRANS + 1000;

   logic                   clk;
   logic                   rst;
   logic                   i_boot;
   logic                   i_i_req;
   int_mem_pkg::i_req_t    i_i_req_s;
   logic                   o_i_ack;
   int_mem_pkg::mem_resp_t o_i_resp;
   logic                   i_d_req;
   int_mem_pkg::d_req_t    i_d_req_s;
   logic                   o_d_ack;
   int_mem_pkg::mem_resp_t o_d_resp;
   logic                   o_load_done;

   // reference copy of the ram contents
   logic [int_mem_pkg::DATA_W-1:0] model [int_mem_pkg::RAM_WORDS];

   logic [31:0] lfsr_state;
   int          value_errs;
   int          other_errs;
   int          cycle_cnt;
   logic        done_seen;
   logic [9:0]  load_wr_addr;

   int_mem dut (
      .clk         (clk),
      .rst         (rst),
      .i_boot      (i_boot),
      .i_i_req     (i_i_req),
      .i_i_req_s   (i_i_req_s),
      .o_i_ack     (o_i_ack),
      .o_i_resp    (o_i_resp),
      .i_d_req     (i_d_req),
      .i_d_req_s   (i_d_req_s),
      .o_d_ack     (o_d_ack),
      .o_d_resp    (o_d_resp),
      .o_load_done (o_load_done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois lfsr for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // boot mode shifts core addresses up by BOOT_BASE and wraps at the ram size
   function automatic logic [9:0] phys_addr(input logic [9:0] a, input logic boot);
      int p;
      p = boot ? (int'(a) + int_mem_pkg::BOOT_BASE) % int_mem_pkg::RAM_WORDS : int'(a);
      return 10'(p);
   endfunction

   function automatic void model_write(input logic [9:0] a, input logic [31:0] d,
                                       input logic [3:0] strb);
      for (int b = 0; b < int_mem_pkg::STRB_W; b++) begin
         if (strb[b]) begin
            model[a][b*8 +: 8] = d[b*8 +: 8];
         end
      end
   endfunction

   // unwritten model bits match anything
   task automatic check_resp(input string name, input int_mem_pkg::mem_resp_t exp,
                             input int_mem_pkg::mem_resp_t act);
      logic bad;
      bad = 1'b0;
      for (int i = 0; i < int_mem_pkg::DATA_W; i++) begin
         if (exp.rdata[i] !== 1'bx && exp.rdata[i] !== act.rdata[i]) begin
            bad = 1'b1;
         end
      end
      if (bad) begin
         value_errs++;
         $display("[FAIL] %s expected %h actual %h", name, exp.rdata, act.rdata);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         value_errs++;
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
      end
   endtask

   // four-phase data transfer through the arbiter
   task automatic data_xfer(input int_mem_pkg::d_req_t req,
                            output int_mem_pkg::mem_resp_t resp);
      @(posedge clk);
      i_d_req   <= 1'b1;
      i_d_req_s <= req;
      do begin
         @(negedge clk);
      end while (!o_d_ack);
      resp = o_d_resp;
      @(posedge clk);
      i_d_req <= 1'b0;
      do begin
         @(negedge clk);
      end while (o_d_ack);
   endtask

   task automatic instr_xfer(input logic [9:0] addr, output int_mem_pkg::mem_resp_t resp,
                             output logic done_at_ack);
      int_mem_pkg::i_req_t req;
      req.addr = addr;
      @(posedge clk);
      i_i_req   <= 1'b1;
      i_i_req_s <= req;
      do begin
         @(negedge clk);
      end while (!o_i_ack);
      resp        = o_i_resp;
      done_at_ack = o_load_done;
      @(posedge clk);
      i_i_req <= 1'b0;
      do begin
         @(negedge clk);
      end while (o_i_ack);
   endtask

   task automatic data_write(input logic [9:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      int_mem_pkg::d_req_t    req;
      int_mem_pkg::mem_resp_t resp;
      req.addr  = addr;
      req.we    = 1'b1;
      req.wdata = data;
      req.strb  = strb;
      data_xfer(req, resp);
      model_write(phys_addr(addr, i_boot), data, strb);
   endtask

   task automatic data_read(input string name, input logic [9:0] addr);
      int_mem_pkg::d_req_t    req;
      int_mem_pkg::mem_resp_t resp;
      int_mem_pkg::mem_resp_t exp;
      req.addr  = addr;
      req.we    = 1'b0;
      req.wdata = '0;
      req.strb  = '0;
      data_xfer(req, resp);
      exp.rdata = model[phys_addr(addr, i_boot)];
      check_resp(name, exp, resp);
   endtask

   task automatic set_boot(input logic b);
      @(posedge clk);
      i_boot <= b;
   endtask

   // load done must stay high once set
   always @(negedge clk) begin
      if (rst === 1'b0) begin
         if (done_seen) begin
            check_flag("load done held", 1'b1, o_load_done);
         end
         if (o_load_done) begin
            done_seen = 1'b1;
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      other_errs++;
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin : main_seq
      int_mem_pkg::mem_resp_t resp;
      int_mem_pkg::mem_resp_t exp;
      logic                   done_at_ack;
      logic [9:0]             addr;
      logic [31:0]            wdata;
      logic [3:0]             strb;
      logic [9:0]             remap_addr [N_REMAP];

      lfsr_state = 32'hf475;
      value_errs = 0;
      other_errs = 0;
      done_seen  = 1'b0;
      rst       <= 1'b1;
      i_boot    <= 1'b0;
      i_i_req   <= 1'b0;
      i_i_req_s <= '0;
      i_d_req   <= 1'b0;
      i_d_req_s <= '0;
      for (int k = 0; k < int_mem_pkg::RAM_WORDS; k++) begin
         model[k] = 'x;
      end
      for (int k = 0; k < int_mem_pkg::BOOT_WORDS; k++) begin
         model[int_mem_pkg::BOOT_BASE + k] = int_mem_pkg::boot_word(6'(k));
      end

      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_flag("load done after reset", 1'b0, o_load_done);
      check_flag("instr ack after reset", 1'b0, o_i_ack);
      check_flag("data ack after reset", 1'b0, o_d_ack);

      // fetch and data write both race the boot copy
      fork
         begin
            instr_xfer(10'(int_mem_pkg::BOOT_BASE), resp, done_at_ack);
            check_flag("fetch held until load done", 1'b1, done_at_ack);
            exp.rdata = int_mem_pkg::boot_word(6'd0);
            check_resp("first fetch", exp, resp);
         end
         begin
            load_wr_addr = 10'(rand_bits(9));
            wdata        = rand_bits(32);
            data_write(load_wr_addr, wdata, 4'hf);
            check_flag("write during load", 1'b0, o_load_done);
         end
      join
      check_flag("load done", 1'b1, o_load_done);

      set_boot(1'b1);
      for (int n = 0; n < N_BOOT_READS; n++) begin
         addr = 10'(rand_bits(6));
         instr_xfer(addr, resp, done_at_ack);
         exp.rdata = int_mem_pkg::boot_word(addr[5:0]);
         check_resp($sformatf("boot fetch %0d", addr), exp, resp);
      end

      // strobed writes into a small window so reads hit them
      set_boot(1'b0);
      for (int n = 0; n < N_RW; n++) begin
         addr  = 10'(rand_bits(6));
         wdata = rand_bits(32);
         strb  = 4'(rand_bits(4));
         data_write(addr, wdata, strb);
      end
      for (int n = 0; n < N_RW; n++) begin
         addr = 10'(rand_bits(6));
         data_read($sformatf("data read %0d", addr), addr);
      end

      for (int n = 0; n < N_IREADS; n++) begin
         addr = 10'(rand_bits(6));
         instr_xfer(addr, resp, done_at_ack);
         exp.rdata = model[addr];
         check_resp($sformatf("fetch of written %0d", addr), exp, resp);
      end

      // remapped data accesses are read back at the physical address
      set_boot(1'b1);
      for (int n = 0; n < N_REMAP; n++) begin
         remap_addr[n] = 10'(rand_bits(10));
         wdata         = rand_bits(32);
         strb          = 4'(rand_bits(4));
         data_write(remap_addr[n], wdata, strb);
      end
      for (int n = 0; n < N_REMAP; n++) begin
         data_read($sformatf("remap read %0d", remap_addr[n]), remap_addr[n]);
      end
      set_boot(1'b0);
      for (int n = 0; n < N_REMAP; n++) begin
         addr = phys_addr(remap_addr[n], 1'b1);
         data_read($sformatf("remap phys %0d", addr), addr);
      end

      data_read("write during load readback", load_wr_addr);
      for (int k = 0; k < int_mem_pkg::BOOT_WORDS; k++) begin
         addr = 10'(int_mem_pkg::BOOT_BASE + k);
         data_read($sformatf("boot region %0d", addr), addr);
      end

      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- int_mem/int_mem.sv
`default_nettype none

module int_mem (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     i_boot,

   // instruction bus
   input  wire                     i_i_req,
   input  wire int_mem_pkg::i_req_t i_i_req_s,
   output logic                    o_i_ack,
   output int_mem_pkg::mem_resp_t  o_i_resp,

   // data bus
   input  wire                     i_d_req,
   input  wire int_mem_pkg::d_req_t i_d_req_s,
   output logic                    o_d_ack,
   output int_mem_pkg::mem_resp_t  o_d_resp,

   output logic                    o_load_done
);

   // loader to rom
   logic [int_mem_pkg::BOOT_ADDR_W-1:0] rom_addr;
   logic [int_mem_pkg::DATA_W-1:0]      rom_data;

   // loader to arbiter master 0
   logic                   ld_req;
   int_mem_pkg::d_req_t    ld_req_s;
   logic                   ld_ack;

   // arbiter to ram data port
   logic                   s_req;
   int_mem_pkg::d_req_t    s_req_s;
   logic                   s_core_sel;
   logic                   s_ack;
   int_mem_pkg::mem_resp_t s_resp;

   logic                   load_done;

   boot_loader u_loader (
      .clk         (clk),
      .rst         (rst),
      .o_rom_addr  (rom_addr),
      .i_rom_data  (rom_data),
      .o_req       (ld_req),
      .o_req_s     (ld_req_s),
      .i_ack       (ld_ack),
      .o_load_done (load_done)
   );

   boot_rom u_rom (
      .clk    (clk),
      .rst    (rst),
      .i_addr (rom_addr),
      .o_data (rom_data)
   );

   // loader only writes, so its read response is left open
   bus_arbiter u_arb (
      .clk          (clk),
      .rst          (rst),
      .i_m0_req     (ld_req),
      .i_m0_req_s   (ld_req_s),
      .o_m0_ack     (ld_ack),
      .o_m0_resp    (),
      .i_m1_req     (i_d_req),
      .i_m1_req_s   (i_d_req_s),
      .o_m1_ack     (o_d_ack),
      .o_m1_resp    (o_d_resp),
      .o_s_req      (s_req),
      .o_s_req_s    (s_req_s),
      .o_s_core_sel (s_core_sel),
      .i_s_ack      (s_ack),
      .i_s_resp     (s_resp)
   );

   dual_port_ram u_ram (
      .clk          (clk),
      .rst          (rst),
      .i_boot       (i_boot),
      .i_load_done  (load_done),
      .i_i_req      (i_i_req),
      .i_i_req_s    (i_i_req_s),
      .o_i_ack      (o_i_ack),
      .o_i_resp     (o_i_resp),
      .i_d_req      (s_req),
      .i_d_req_s    (s_req_s),
      .i_d_core_sel (s_core_sel),
      .o_d_ack      (s_ack),
      .o_d_resp     (s_resp)
   );

   assign o_load_done = load_done;

endmodule

`default_nettype wire

//--- int_mem/dual_port_ram.sv
`default_nettype none

module dual_port_ram (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      i_boot,
   input  wire                      i_load_done,

   // instruction port, read only
   input  wire                      i_i_req,
   input  wire int_mem_pkg::i_req_t i_i_req_s,
   output logic                     o_i_ack,
   output int_mem_pkg::mem_resp_t   o_i_resp,

   // data port, from the arbiter
   input  wire                      i_d_req,
   input  wire int_mem_pkg::d_req_t i_d_req_s,
   input  wire                      i_d_core_sel,
   output logic                     o_d_ack,
   output int_mem_pkg::mem_resp_t   o_d_resp
);

   localparam logic [int_mem_pkg::ADDR_W-1:0] BOOT_OFS =
      int_mem_pkg::ADDR_W'(int_mem_pkg::BOOT_BASE);

   logic [int_mem_pkg::DATA_W-1:0] mem [int_mem_pkg::RAM_WORDS];

   logic [int_mem_pkg::ADDR_W-1:0] i_addr;
   logic [int_mem_pkg::ADDR_W-1:0] d_addr;
   logic                           i_fire;
   logic                           d_fire;

   // boot remap, wraps at the ram size
   assign i_addr = i_boot ? i_i_req_s.addr + BOOT_OFS : i_i_req_s.addr;

   // loader addresses are absolute already
   assign d_addr = (i_boot && i_d_core_sel) ? i_d_req_s.addr + BOOT_OFS : i_d_req_s.addr;

   // access happens on the edge that raises ack
   assign i_fire = i_i_req && !o_i_ack && i_load_done;
   assign d_fire = i_d_req && !o_d_ack;

   // instruction responder, held off until the boot copy is done
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_i_ack <= 1'b0;
      end else if (i_fire) begin
         o_i_ack <= 1'b1;
      end else if (!i_i_req && o_i_ack) begin
         o_i_ack <= 1'b0;
      end
   end

   // data responder
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_d_ack <= 1'b0;
      end else if (d_fire) begin
         o_d_ack <= 1'b1;
      end else if (!i_d_req && o_d_ack) begin
         o_d_ack <= 1'b0;
      end
   end

   // instruction read
   always_ff @(posedge clk) begin
      if (i_fire) begin
         o_i_resp.rdata <= mem[i_addr];
      end
   end

   // data read, old contents on a write
   always_ff @(posedge clk) begin
      if (d_fire) begin
         o_d_resp.rdata <= mem[d_addr];
      end
   end

   // byte lanes written under strobe
   always_ff @(posedge clk) begin
      if (d_fire && i_d_req_s.we) begin
         for (int b = 0; b < int_mem_pkg::STRB_W; b++) begin
            if (i_d_req_s.strb[b]) begin
               mem[d_addr][b*8 +: 8] <= i_d_req_s.wdata[b*8 +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- int_mem/boot_loader.sv
`default_nettype none

module boot_loader (
   input  wire                                 clk,
   input  wire                                 rst,
   output logic [int_mem_pkg::BOOT_ADDR_W-1:0] o_rom_addr,
   input  wire  [int_mem_pkg::DATA_W-1:0]      i_rom_data,
   output logic                                o_req,
   output int_mem_pkg::d_req_t                 o_req_s,
   input  wire                                 i_ack,
   output logic                                o_load_done
);

   typedef enum logic [2:0] {
      S_FETCH,
      S_REQ,
      S_WAIT,
      S_REL,
      S_DONE
   } state_t;

   state_t state;

   // index of the word being copied
   logic [int_mem_pkg::BOOT_ADDR_W-1:0] word_cnt;
   logic                                last_word;

   // rom address follows the counter, data is back one cycle later
   assign o_rom_addr = word_cnt;
   assign last_word  = (word_cnt == int_mem_pkg::BOOT_ADDR_W'(int_mem_pkg::BOOT_WORDS - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= S_FETCH;
         word_cnt    <= '0;
         o_req       <= 1'b0;
         o_load_done <= 1'b0;
      end else begin
         case (state)
            // address is on the rom this cycle
            S_FETCH: begin
               state <= S_REQ;
            end
            // rom data valid, payload is captured below
            S_REQ: begin
               o_req <= 1'b1;
               state <= S_WAIT;
            end
            S_WAIT: begin
               if (i_ack) begin
                  o_req <= 1'b0;
                  state <= S_REL;
               end
            end
            // hold until the slave drops ack
            S_REL: begin
               if (!i_ack) begin
                  if (last_word) begin
                     o_load_done <= 1'b1;
                     state       <= S_DONE;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                     state    <= S_FETCH;
                  end
               end
            end
            S_DONE: begin
               state <= S_DONE;
            end
            default: begin
               state <= S_DONE;
            end
         endcase
      end
   end

   // write payload, stable from req rise until after req falls
   always_ff @(posedge clk) begin
      if (state == S_REQ) begin
         o_req_s.addr  <= int_mem_pkg::ADDR_W'(int_mem_pkg::BOOT_BASE + word_cnt);
         o_req_s.we    <= 1'b1;
         o_req_s.wdata <= i_rom_data;
         o_req_s.strb  <= '1;
      end
   end

endmodule

`default_nettype wire

//--- int_mem/boot_rom.sv
`default_nettype none

module boot_rom (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire  [int_mem_pkg::BOOT_ADDR_W-1:0] i_addr,
   output logic [int_mem_pkg::DATA_W-1:0]      o_data
);

   // constant table of the boot program
   logic [int_mem_pkg::DATA_W-1:0] rom_tbl [int_mem_pkg::BOOT_WORDS];

   genvar k;
   generate
      for (k = 0; k < int_mem_pkg::BOOT_WORDS; k++) begin : g_word
         assign rom_tbl[k] = int_mem_pkg::boot_word(int_mem_pkg::BOOT_ADDR_W'(k));
      end
   endgenerate

   // registered read, one cycle of latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_data <= '0;
      end else begin
         o_data <= rom_tbl[i_addr];
      end
   end

endmodule

`default_nettype wire

//--- verilog/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
   input  wire                      clk,
   input  wire                      rst,

   // master 0, the boot loader, wins ties
   input  wire                      i_m0_req,
   input  wire int_mem_pkg::d_req_t i_m0_req_s,
   output logic                     o_m0_ack,
   output int_mem_pkg::mem_resp_t   o_m0_resp,

   // master 1, the core data bus
   input  wire                      i_m1_req,
   input  wire int_mem_pkg::d_req_t i_m1_req_s,
   output logic                     o_m1_ack,
   output int_mem_pkg::mem_resp_t   o_m1_resp,

   // single slave
   output logic                     o_s_req,
   output int_mem_pkg::d_req_t      o_s_req_s,
   output logic                     o_s_core_sel,
   input  wire                      i_s_ack,
   input  wire int_mem_pkg::mem_resp_t i_s_resp
);

   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_M0,
      GNT_M1
   } grant_t;

   grant_t grant;

   // slave has acked within the current grant
   logic ack_seen;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         grant    <= GNT_NONE;
         ack_seen <= 1'b0;
      end else if (grant == GNT_NONE) begin
         ack_seen <= 1'b0;
         if (i_m0_req) begin
            grant <= GNT_M0;
         end else if (i_m1_req) begin
            grant <= GNT_M1;
         end
      end else if (i_s_ack) begin
         ack_seen <= 1'b1;
      end else if (ack_seen) begin
         // falling ack closes the transaction
         grant    <= GNT_NONE;
         ack_seen <= 1'b0;
      end
   end

   // request path, live only while a grant is held
   always_comb begin
      case (grant)
         GNT_M0: o_s_req = i_m0_req;
         GNT_M1: o_s_req = i_m1_req;
         default: o_s_req = 1'b0;
      endcase
   end

   assign o_s_req_s    = (grant == GNT_M1) ? i_m1_req_s : i_m0_req_s;
   assign o_s_core_sel = (grant == GNT_M1);

   // ack and response only reach the granted master
   assign o_m0_ack  = (grant == GNT_M0) && i_s_ack;
   assign o_m1_ack  = (grant == GNT_M1) && i_s_ack;
   assign o_m0_resp = (grant == GNT_M0) ? i_s_resp : '0;
   assign o_m1_resp = (grant == GNT_M1) ? i_s_resp : '0;

endmodule

`default_nettype wire

//--- common/int_mem_pkg.sv
`default_nettype none

package int_mem_pkg;

   // word address into the RAM
   localparam int ADDR_W = 10;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   localparam int RAM_WORDS = 1 << ADDR_W;

   // boot program size and placement
   localparam int BOOT_ADDR_W = 6;
   localparam int BOOT_WORDS = 1 << BOOT_ADDR_W;
   localparam int BOOT_BASE = RAM_WORDS - BOOT_WORDS;

   // data bus request, 47 bits
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              we;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] strb;
   } d_req_t;

   // instruction fetch request
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } i_req_t;

   // response from either RAM port
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
   } mem_resp_t;

   // boot program word k, a fixed integer hash of the index
   function automatic logic [DATA_W-1:0] boot_word(input logic [BOOT_ADDR_W-1:0] k);
      logic [DATA_W-1:0] x;
      x = DATA_W'(k) * 32'h9e37_79b9;
      x = x ^ (x >> 15);
      x = x * 32'h85eb_ca6b;
      x = x ^ (x >> 13);
      x = x ^ 32'h5a5a_c3c3;
      return x;
   endfunction

endpackage

`default_nettype wire
